// File: design/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath and address width of the core
`define CORE_XLEN 32

// Architectural register file size
`define CORE_NREGS 32

// Register index width, log2 of the register count
`define CORE_REG_AW 5

// Immediate field width of I-type words
`define CORE_IMM_W 16

// Jump index width of J-type words
`define CORE_JIDX_W 26

`endif

// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// Primary opcodes, instruction bits 31:26
	localparam logic [5:0] op_rtype = 6'h00;	// Special, decoded by funct
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_slti  = 6'h0a;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_xori  = 6'h0e;
	localparam logic [5:0] op_lui   = 6'h0f;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	// Funct codes of the special opcode, bits 5:0
	localparam logic [5:0] fn_jr   = 6'h08;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_slt  = 6'h2a;
	localparam logic [5:0] fn_sltu = 6'h2b;

	// Field boundaries inside the 32-bit word
	localparam int unsigned op_hi  = 31;
	localparam int unsigned op_lo  = 26;
	localparam int unsigned rs_hi  = 25;
	localparam int unsigned rs_lo  = 21;
	localparam int unsigned rt_hi  = 20;
	localparam int unsigned rt_lo  = 16;
	localparam int unsigned rd_hi  = 15;
	localparam int unsigned rd_lo  = 11;
	localparam int unsigned fn_hi  = 5;
	localparam int unsigned fn_lo  = 0;
	localparam int unsigned imm_hi = 15;
	localparam int unsigned imm_lo = 0;
	localparam int unsigned idx_hi = 25;
	localparam int unsigned idx_lo = 0;

endpackage

`default_nettype wire

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

	// ALU operation chosen by the decoder
	typedef enum logic [3:0] {
		alu_add  = 4'd0,	// addu, addiu, lw/sw address
		alu_sub  = 4'd1,	// subu, branch compare
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_slt  = 4'd5,	// Signed compare
		alu_sltu = 4'd6,	// Unsigned compare
		alu_lui  = 4'd7	// Immediate into the upper half
	} alu_op_t;

	// Register writeback source
	typedef enum logic [1:0] {
		wb_alu  = 2'd0,
		wb_mem  = 2'd1,	// Load data
		wb_link = 2'd2	// Return address for jal
	} wb_sel_t;

	// Next pc source
	typedef enum logic [1:0] {
		pc_seq    = 2'd0,	// pc + 4
		pc_branch = 2'd1,	// Conditional, decided by zero and branch_ne
		pc_jump   = 2'd2,	// j and jal
		pc_reg    = 2'd3	// jr
	} pc_sel_t;

	// Destination register field
	typedef enum logic [1:0] {
		dst_rt  = 2'd0,	// I-type
		dst_rd  = 2'd1,	// R-type
		dst_r31 = 2'd2	// Link register
	} dst_sel_t;

endpackage

`default_nettype wire

// File: design/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  wire logic [5:0]         opcode,
	input  wire logic [5:0]         funct,
	output core_pkg::alu_op_t       alu_op,
	output core_pkg::wb_sel_t       wb_sel,
	output core_pkg::pc_sel_t       pc_sel,
	output core_pkg::dst_sel_t      dst_sel,
	output logic                    alu_src_imm,	// 1: ALU b from immediate
	output logic                    sign_ext,	// 1: sign-extend immediate
	output logic                    reg_we,
	output logic                    mem_we,
	output logic                    branch_ne	// 1: bne, taken when not equal
);

	always_comb begin
		alu_op      = core_pkg::alu_add;	// Defaults form a no-op
		wb_sel      = core_pkg::wb_alu;
		pc_sel      = core_pkg::pc_seq;
		dst_sel     = core_pkg::dst_rt;
		alu_src_imm = 1'b0;
		sign_ext    = 1'b1;
		reg_we      = 1'b0;
		mem_we      = 1'b0;
		branch_ne   = 1'b0;
		case (opcode)
			isa_pkg::op_rtype: begin
				dst_sel = core_pkg::dst_rd;
				reg_we  = 1'b1;	// Cleared below for jr and unknown funct
				case (funct)
					isa_pkg::fn_addu: alu_op = core_pkg::alu_add;
					isa_pkg::fn_subu: alu_op = core_pkg::alu_sub;
					isa_pkg::fn_and:  alu_op = core_pkg::alu_and;
					isa_pkg::fn_or:   alu_op = core_pkg::alu_or;
					isa_pkg::fn_xor:  alu_op = core_pkg::alu_xor;
					isa_pkg::fn_slt:  alu_op = core_pkg::alu_slt;
					isa_pkg::fn_sltu: alu_op = core_pkg::alu_sltu;
					isa_pkg::fn_jr: begin
						pc_sel = core_pkg::pc_reg;	// Target from rs
						reg_we = 1'b0;
					end
					default: reg_we = 1'b0;	// Unsupported funct
				endcase
			end
			isa_pkg::op_addiu, isa_pkg::op_slti, isa_pkg::op_andi,
			isa_pkg::op_ori, isa_pkg::op_xori, isa_pkg::op_lui: begin
				alu_src_imm = 1'b1;
				reg_we      = 1'b1;
				// Only the arithmetic forms extend the sign
				sign_ext    = (opcode == isa_pkg::op_addiu) || (opcode == isa_pkg::op_slti);
				case (opcode)
					isa_pkg::op_slti: alu_op = core_pkg::alu_slt;
					isa_pkg::op_andi: alu_op = core_pkg::alu_and;
					isa_pkg::op_ori:  alu_op = core_pkg::alu_or;
					isa_pkg::op_xori: alu_op = core_pkg::alu_xor;
					isa_pkg::op_lui:  alu_op = core_pkg::alu_lui;
					default:          alu_op = core_pkg::alu_add;
				endcase
			end
			isa_pkg::op_lw: begin
				alu_src_imm = 1'b1;	// Address is rs + offset
				wb_sel      = core_pkg::wb_mem;
				reg_we      = 1'b1;
			end
			isa_pkg::op_sw: begin
				alu_src_imm = 1'b1;
				mem_we      = 1'b1;
			end
			isa_pkg::op_beq, isa_pkg::op_bne: begin
				alu_op    = core_pkg::alu_sub;	// Operands rs and rt
				pc_sel    = core_pkg::pc_branch;
				branch_ne = (opcode == isa_pkg::op_bne);
			end
			isa_pkg::op_j: pc_sel = core_pkg::pc_jump;
			isa_pkg::op_jal: begin
				pc_sel  = core_pkg::pc_jump;
				wb_sel  = core_pkg::wb_link;	// r31 gets pc + 4
				dst_sel = core_pkg::dst_r31;
				reg_we  = 1'b1;
			end
			default: ;	// Unknown opcode runs as a no-op
		endcase
	end

endmodule

`default_nettype wire

// File: design/register_bank.sv
`timescale 1ns/1ps
`include "core_macros.svh"
`default_nettype none

module register_bank (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic [`CORE_REG_AW-1:0] raddr1,	// rs
	input  wire logic [`CORE_REG_AW-1:0] raddr2,	// rt
	input  wire logic [`CORE_REG_AW-1:0] waddr,
	input  wire logic                    we,
	input  wire logic [`CORE_XLEN-1:0]   wdata,
	output logic      [`CORE_XLEN-1:0]   rdata1,
	output logic      [`CORE_XLEN-1:0]   rdata2
);

	logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];	// Entry 0 never written

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;	// Program restarts from a clean file
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;	// Writes to r0 dropped
		end
	end

	// Reads see the old value during a write to the same index
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`include "core_macros.svh"
`default_nettype none

module alu (
	input  wire logic [`CORE_XLEN-1:0] a,	// rs value
	input  wire logic [`CORE_XLEN-1:0] b,	// rt value or extended immediate
	input  core_pkg::alu_op_t          op,
	output logic      [`CORE_XLEN-1:0] result,
	output logic                       zero
);

	localparam int half = `CORE_XLEN / 2;

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			core_pkg::alu_add:  result = a + b;	// Wraps, no overflow trap
			core_pkg::alu_sub:  result = a - b;
			core_pkg::alu_and:  result = a & b;
			core_pkg::alu_or:   result = a | b;
			core_pkg::alu_xor:  result = a ^ b;
			core_pkg::alu_slt:  result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
			core_pkg::alu_sltu: result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
			core_pkg::alu_lui:  result = {b[half-1:0], {half{1'b0}}};	// Low half of b moved up
			default:            result = '0;
		endcase
	end

	// Equality flag, independent of op, for beq and bne
	assign zero = (a == b);

endmodule

`default_nettype wire

// File: design/program_counter.sv
`timescale 1ns/1ps
`include "core_macros.svh"
`default_nettype none

module program_counter (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  core_pkg::pc_sel_t              pc_sel,
	input  wire logic                      zero,	// rs == rt from the ALU
	input  wire logic                      branch_ne,
	input  wire logic [`CORE_XLEN-1:0]     imm_ext,	// Sign-extended word offset
	input  wire logic [`CORE_JIDX_W-1:0]   jump_index,
	input  wire logic [`CORE_XLEN-1:0]     reg_target,	// rs for jr
	output logic      [`CORE_XLEN-1:0]     pc,
	output logic      [`CORE_XLEN-1:0]     pc_plus4	// Also the link value
);

	logic                  taken;
	logic [`CORE_XLEN-1:0] branch_target;
	logic [`CORE_XLEN-1:0] jump_target;
	logic [`CORE_XLEN-1:0] pc_next;

	assign pc_plus4      = pc + `CORE_XLEN'd4;
	assign taken         = zero ^ branch_ne;	// beq on equal, bne on not equal
	assign branch_target = pc_plus4 + {imm_ext[`CORE_XLEN-3:0], 2'b00};
	assign jump_target   = {pc_plus4[`CORE_XLEN-1:`CORE_JIDX_W+2], jump_index, 2'b00};	// Same 256 MB region

	always_comb begin
		case (pc_sel)
			core_pkg::pc_branch: pc_next = taken ? branch_target : pc_plus4;
			core_pkg::pc_jump:   pc_next = jump_target;
			core_pkg::pc_reg:    pc_next = reg_target;
			default:             pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;	// Fetch restarts at address 0
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

// File: design/mips_uniciclo.sv
`timescale 1ns/1ps
`include "core_macros.svh"
`default_nettype none

module mips_uniciclo (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	output logic      [`CORE_XLEN-1:0]   imem_addr,	// Byte address, asynchronous read
	input  wire logic [`CORE_XLEN-1:0]   imem_data,
	output logic      [`CORE_XLEN-1:0]   dmem_addr,
	output logic      [`CORE_XLEN-1:0]   dmem_wdata,
	output logic                         dmem_we,	// Captured at the next rising edge
	input  wire logic [`CORE_XLEN-1:0]   dmem_rdata,
	output logic                         rf_we,	// Register write of this cycle
	output logic      [`CORE_REG_AW-1:0] rf_waddr,
	output logic      [`CORE_XLEN-1:0]   rf_wdata
);

	logic [5:0]                opcode;
	logic [5:0]                funct;
	logic [`CORE_REG_AW-1:0]   rs;
	logic [`CORE_REG_AW-1:0]   rt;
	logic [`CORE_REG_AW-1:0]   rd;
	logic [`CORE_IMM_W-1:0]    imm;
	logic [`CORE_JIDX_W-1:0]   jump_index;

	core_pkg::alu_op_t  alu_op;
	core_pkg::wb_sel_t  wb_sel;
	core_pkg::pc_sel_t  pc_sel;
	core_pkg::dst_sel_t dst_sel;
	logic               alu_src_imm;
	logic               sign_ext;
	logic               reg_we;
	logic               mem_we;
	logic               branch_ne;

	logic [`CORE_XLEN-1:0] rs_data;
	logic [`CORE_XLEN-1:0] rt_data;
	logic [`CORE_XLEN-1:0] imm_ext;
	logic [`CORE_XLEN-1:0] alu_b;
	logic [`CORE_XLEN-1:0] alu_result;
	logic                  zero;
	logic [`CORE_XLEN-1:0] pc;
	logic [`CORE_XLEN-1:0] pc_plus4;

	// Instruction fields
	assign opcode     = imem_data[isa_pkg::op_hi:isa_pkg::op_lo];
	assign rs         = imem_data[isa_pkg::rs_hi:isa_pkg::rs_lo];
	assign rt         = imem_data[isa_pkg::rt_hi:isa_pkg::rt_lo];
	assign rd         = imem_data[isa_pkg::rd_hi:isa_pkg::rd_lo];
	assign funct      = imem_data[isa_pkg::fn_hi:isa_pkg::fn_lo];
	assign imm        = imem_data[isa_pkg::imm_hi:isa_pkg::imm_lo];
	assign jump_index = imem_data[isa_pkg::idx_hi:isa_pkg::idx_lo];

	// Logical immediates take zeros on top
	assign imm_ext = sign_ext ? {{(`CORE_XLEN-`CORE_IMM_W){imm[`CORE_IMM_W-1]}}, imm}
	                          : {{(`CORE_XLEN-`CORE_IMM_W){1'b0}}, imm};
	assign alu_b   = alu_src_imm ? imm_ext : rt_data;

	always_comb begin
		case (dst_sel)
			core_pkg::dst_rd:  rf_waddr = rd;
			core_pkg::dst_r31: rf_waddr = '1;	// Link register r31
			default:           rf_waddr = rt;
		endcase
		case (wb_sel)
			core_pkg::wb_mem:  rf_wdata = dmem_rdata;
			core_pkg::wb_link: rf_wdata = pc_plus4;
			default:           rf_wdata = alu_result;
		endcase
	end

	assign rf_we      = reg_we & rst_n;	// Held low during reset
	assign dmem_we    = mem_we & rst_n;
	assign dmem_addr  = alu_result;
	assign dmem_wdata = rt_data;	// Store data from rt
	assign imem_addr  = pc;

	control_unit ctrl_i (
		.opcode      (opcode),
		.funct       (funct),
		.alu_op      (alu_op),
		.wb_sel      (wb_sel),
		.pc_sel      (pc_sel),
		.dst_sel     (dst_sel),
		.alu_src_imm (alu_src_imm),
		.sign_ext    (sign_ext),
		.reg_we      (reg_we),
		.mem_we      (mem_we),
		.branch_ne   (branch_ne)
	);

	register_bank regs_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (rs),
		.raddr2 (rt),
		.waddr  (rf_waddr),
		.we     (rf_we),
		.wdata  (rf_wdata),
		.rdata1 (rs_data),
		.rdata2 (rt_data)
	);

	alu alu_i (
		.a      (rs_data),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.zero   (zero)
	);

	program_counter pc_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.pc_sel     (pc_sel),
		.zero       (zero),
		.branch_ne  (branch_ne),
		.imm_ext    (imm_ext),
		.jump_index (jump_index),
		.reg_target (rs_data),	// jr target
		.pc         (pc),
		.pc_plus4   (pc_plus4)
	);

endmodule

`default_nettype wire

// File: dv/mips_checker.sv
`timescale 1ns/1ps
`include "core_macros.svh"
`default_nettype none

module mips_checker (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic [`CORE_XLEN-1:0]   imem_addr,
	input  wire logic [`CORE_XLEN-1:0]   imem_data,
	input  wire logic [`CORE_XLEN-1:0]   dmem_addr,
	input  wire logic [`CORE_XLEN-1:0]   dmem_wdata,
	input  wire logic                    dmem_we,
	input  wire logic                    rf_we,
	input  wire logic [`CORE_REG_AW-1:0] rf_waddr,
	input  wire logic [`CORE_XLEN-1:0]   rf_wdata,
	output int                           errors
);

	logic [`CORE_XLEN-1:0]   regs [`CORE_NREGS];	// Model register file
	logic [`CORE_XLEN-1:0]   mem [256];	// Model data memory, word index 9:2
	logic [`CORE_XLEN-1:0]   mpc;
	logic                    exp_we;
	logic                    exp_st;
	logic [`CORE_REG_AW-1:0] exp_wa;
	logic [`CORE_XLEN-1:0]   exp_wd;
	logic [`CORE_XLEN-1:0]   exp_sa;
	logic [`CORE_XLEN-1:0]   exp_sd;
	logic [`CORE_XLEN-1:0]   exp_pc;
	int                      err_count = 0;

	assign errors = err_count;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			err_count++;
			$display("Error: %s expected 0x%08h actual 0x%08h at pc 0x%08h", name, exp, act, mpc);
		end
	endtask

	// Architectural effect of one instruction word on the model state
	task automatic predict(input logic [31:0] ins);
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] zx;
		logic [31:0] pc4;
		op  = ins[31:26];
		fn  = ins[5:0];
		rs  = ins[25:21];
		rt  = ins[20:16];
		a   = regs[rs];	// r0 stays zero, never written
		b   = regs[rt];
		sx  = {{16{ins[15]}}, ins[15:0]};
		zx  = {16'h0000, ins[15:0]};
		pc4 = mpc + 32'd4;
		exp_we = 1'b0;
		exp_st = 1'b0;
		exp_wa = rt;
		exp_wd = '0;
		exp_sa = a + sx;
		exp_sd = b;
		exp_pc = pc4;
		case (op)
			isa_pkg::op_rtype: begin
				exp_wa = ins[15:11];
				exp_we = 1'b1;
				case (fn)
					isa_pkg::fn_addu: exp_wd = a + b;
					isa_pkg::fn_subu: exp_wd = a - b;
					isa_pkg::fn_and:  exp_wd = a & b;
					isa_pkg::fn_or:   exp_wd = a | b;
					isa_pkg::fn_xor:  exp_wd = a ^ b;
					isa_pkg::fn_slt:  exp_wd = {31'b0, $signed(a) < $signed(b)};
					isa_pkg::fn_sltu: exp_wd = {31'b0, a < b};
					isa_pkg::fn_jr: begin
						exp_we = 1'b0;
						exp_pc = a;
					end
					default: exp_we = 1'b0;	// Unknown funct is a no-op
				endcase
			end
			isa_pkg::op_addiu: {exp_we, exp_wd} = {1'b1, a + sx};
			isa_pkg::op_slti:  {exp_we, exp_wd} = {1'b1, 31'b0, $signed(a) < $signed(sx)};
			isa_pkg::op_andi:  {exp_we, exp_wd} = {1'b1, a & zx};
			isa_pkg::op_ori:   {exp_we, exp_wd} = {1'b1, a | zx};
			isa_pkg::op_xori:  {exp_we, exp_wd} = {1'b1, a ^ zx};
			isa_pkg::op_lui:   {exp_we, exp_wd} = {1'b1, ins[15:0], 16'h0000};
			isa_pkg::op_lw:    {exp_we, exp_wd} = {1'b1, mem[exp_sa[9:2]]};
			isa_pkg::op_sw:    exp_st = 1'b1;
			isa_pkg::op_beq:   if (a == b) exp_pc = pc4 + {sx[29:0], 2'b00};
			isa_pkg::op_bne:   if (a != b) exp_pc = pc4 + {sx[29:0], 2'b00};
			isa_pkg::op_j:     exp_pc = {pc4[31:28], ins[25:0], 2'b00};
			isa_pkg::op_jal: begin
				exp_pc = {pc4[31:28], ins[25:0], 2'b00};
				exp_we = 1'b1;
				exp_wa = 5'd31;	// Link register
				exp_wd = pc4;
			end
			default: ;
		endcase
	endtask

	// Outputs are settled mid-cycle, well after the 1 ns input update
	always @(negedge clk) begin
		if (rst_n) begin
			predict(imem_data);
			compare("imem_addr", mpc, imem_addr);
			if (exp_we && (exp_wa != 5'd0)) begin
				compare("rf_we", 32'd1, {31'b0, rf_we});
				compare("rf_waddr", {27'b0, exp_wa}, {27'b0, rf_waddr});
				compare("rf_wdata", exp_wd, rf_wdata);
			end else if (!exp_we) begin
				compare("rf_we", 32'd0, {31'b0, rf_we});
			end
			compare("dmem_we", {31'b0, exp_st}, {31'b0, dmem_we});
			if (exp_st) begin
				compare("dmem_addr", exp_sa, dmem_addr);
				compare("dmem_wdata", exp_sd, dmem_wdata);
			end
		end
	end

	// Prediction of the previous falling edge retires here
	always @(posedge clk) begin
		if (!rst_n) begin
			mpc <= '0;
			for (int i = 0; i < `CORE_NREGS; i++) regs[i] <= '0;
			for (int i = 0; i < 256; i++) mem[i] <= '0;
		end else begin
			if (exp_we && (exp_wa != 5'd0)) regs[exp_wa] <= exp_wd;
			if (exp_st) mem[exp_sa[9:2]] <= exp_sd;
			mpc <= exp_pc;
		end
	end

endmodule

`default_nettype wire

// File: dv/tb_mips.sv
`timescale 1ns/1ps
`include "core_macros.svh"
`default_nettype none

module tb_mips;

	logic                    clk;
	logic                    rst_n;
	logic [`CORE_XLEN-1:0]   imem_addr;
	logic [`CORE_XLEN-1:0]   imem_data;
	logic [`CORE_XLEN-1:0]   dmem_addr;
	logic [`CORE_XLEN-1:0]   dmem_wdata;
	logic                    dmem_we;
	logic [`CORE_XLEN-1:0]   dmem_rdata;
	logic                    rf_we;
	logic [`CORE_REG_AW-1:0] rf_waddr;
	logic [`CORE_XLEN-1:0]   rf_wdata;
	logic [31:0]             imem [256];
	logic [31:0]             dmem [256];
	integer                  seed = 32'hde34_da88;
	int                      errors;
	int                      pass_count = 0;
	int                      fail_count = 0;

	assign imem_data  = imem[imem_addr[9:2]];	// Asynchronous reads
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) dmem[i] <= '0;	// Cleared on every reset
		end else if (dmem_we) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	mips_uniciclo dut_i (
		.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata), .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
	);

	mips_checker check_i (
		.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata), .errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function int rand_below(input int n);
		rand_below = ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function logic [4:0] rreg(input int n);
		rreg = 5'(rand_below(n));
	endfunction

	function logic [15:0] r16();
		r16 = 16'($random(seed));
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] fn);
		enc_r = {isa_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		enc_i = {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input int idx);
		enc_j = {op, 26'(idx)};	// Word index of the target
	endfunction

	function automatic logic [5:0] r_funct(input int k);
		case (k)
			0: r_funct = isa_pkg::fn_addu;
			1: r_funct = isa_pkg::fn_subu;
			2: r_funct = isa_pkg::fn_and;
			3: r_funct = isa_pkg::fn_or;
			4: r_funct = isa_pkg::fn_xor;
			5: r_funct = isa_pkg::fn_slt;
			default: r_funct = isa_pkg::fn_sltu;
		endcase
	endfunction

	function automatic logic [5:0] i_opcode(input int k);
		case (k)
			0: i_opcode = isa_pkg::op_addiu;
			1: i_opcode = isa_pkg::op_slti;
			2: i_opcode = isa_pkg::op_andi;
			3: i_opcode = isa_pkg::op_ori;
			4: i_opcode = isa_pkg::op_xori;
			default: i_opcode = isa_pkg::op_lui;
		endcase
	endfunction

	// 40 random words of the test's mix, then a self-loop at word 40
	task automatic load_program(input int test);
		int i;
		int k;
		int t;
		logic [4:0] r;
		bit hit [41];	// Words that some j, jal or jr lands on
		for (i = 0; i < 256; i++) imem[i] = enc_j(isa_pkg::op_j, i);	// Each word jumps to itself
		for (i = 0; i < 41; i++) hit[i] = 1'b0;
		i = 0;
		while (i < 40) begin
			k = rand_below(4);
			case (test)
				1: if (i < 16) begin
					r = 5'(i / 2 + 1);	// Seed r1..r8 with lui/ori pairs
					imem[i] = (i % 2 == 0) ? enc_i(isa_pkg::op_lui, 5'd0, r, r16())
					                       : enc_i(isa_pkg::op_ori, r, r, r16());
				end else begin
					imem[i] = enc_r(rreg(9), rreg(9), rreg(16), r_funct(rand_below(7)));
				end
				2: imem[i] = enc_i(i_opcode(rand_below(6)), rreg(32), rreg(32), r16());
				3: if (k == 0) imem[i] = enc_i(isa_pkg::op_addiu, 5'd0, rreg(8), r16());
					else imem[i] = enc_i((k == 1) ? isa_pkg::op_lw : isa_pkg::op_sw, 5'd0,
						rreg(8), 16'(rand_below(8) * 4));	// Few addresses, so they repeat
				4: if (k < 2) imem[i] = enc_i(isa_pkg::op_addiu, 5'd0, rreg(4), 16'(k));
					else imem[i] = enc_i((k == 2) ? isa_pkg::op_beq : isa_pkg::op_bne,
						rreg(4), rreg(4), 16'(rand_below(40 - i)));	// Forward, at most word 40
				5: if (k == 1 || k == 2) begin
					t = i + 1 + rand_below(40 - i);
					hit[t] = 1'b1;
					imem[i] = enc_j((k == 1) ? isa_pkg::op_j : isa_pkg::op_jal, t);
				end else if (k == 3 && i <= 37 && !hit[i + 1] && !hit[i + 2]) begin
					// Triple is entered only at its lui
					r = 5'(rand_below(30) + 1);
					t = i + 3 + rand_below(38 - i);
					hit[t] = 1'b1;
					imem[i] = enc_i(isa_pkg::op_lui, 5'd0, r, 16'h0000);
					imem[i + 1] = enc_i(isa_pkg::op_ori, r, r, 16'(t * 4));
					imem[i + 2] = enc_r(r, 5'd0, 5'd0, isa_pkg::fn_jr);
					i = i + 2;
				end else begin
					imem[i] = enc_i(isa_pkg::op_addiu, 5'd0, rreg(32), r16());
				end
				default: imem[i] = enc_r(rreg(32), 5'd0, 5'(rand_below(31) + 1), isa_pkg::fn_addu);
			endcase
			i++;
		end
	endtask

	task automatic restart_with_program(input int test);
		rst_n = 1'b0;
		load_program(test);
		for (int n = 0; n < 10; n++) @(posedge clk);
		#1 rst_n = 1'b1;
	endtask

	// pc unchanged over two cycles means the final self-loop is reached
	task automatic wait_self_loop(output bit ok);
		int cycles;
		int same;
		logic [31:0] prev;
		ok = 1'b0;
		same = 0;
		prev = imem_addr;
		for (cycles = 0; cycles < 500 && !ok; cycles++) begin
			@(negedge clk);
			same = (imem_addr == prev) ? same + 1 : 0;
			prev = imem_addr;
			if (same >= 2) ok = 1'b1;
		end
	endtask

	task automatic run_test(input int test, input string name);
		int err_before;
		bit ok;
		err_before = errors;
		if (test == 6) begin
			restart_with_program(2);	// Leave registers dirty first
			for (int n = 0; n < 20; n++) @(posedge clk);
			#1;
		end
		restart_with_program(test);
		wait_self_loop(ok);
		if (!ok) $display("Test %0d %s: timeout, pc never reached the final self-loop", test, name);
		if (ok && errors == err_before) begin
			pass_count++;
			$display("Test %0d %s: PASS", test, name);
		end else begin
			fail_count++;
			$display("Test %0d %s: FAIL", test, name);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		run_test(1, "rtype_alu");
		run_test(2, "immediates");
		run_test(3, "load_store");
		run_test(4, "branches");
		run_test(5, "jumps");
		run_test(6, "mid_reset");
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/isa_pkg.sv
design/core_pkg.sv
design/control_unit.sv
design/register_bank.sv
design/alu.sv
design/program_counter.sv
design/mips_uniciclo.sv
dv/mips_checker.sv
dv/tb_mips.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 --top-module tb_mips -f filelist.f -o Vtb_mips

run: compile
	@out="$$(./obj_dir/Vtb_mips)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
